/* project.f */
rtl/riscv_pkg.sv
rtl/riscv_ctrl_if.sv
rtl/riscv_decode.sv
rtl/riscv_imm_gen.sv
rtl/riscv_regfile.sv
rtl/riscv_execute.sv
rtl/riscv_exec_top.sv
bench/riscv_exec_chk.sv
bench/riscv_exec_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := riscv_exec_tb
FILELIST := project.f
OBJ_DIR  := obj_dir
PASS_MSG := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/riscv_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_exec_tb import riscv_pkg::*; ();

  localparam int NUM_INST     = 2000;
  localparam int MAX_GAP      = 3;
  localparam int CLK_NS       = 4;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + (NUM_INST + 3) * (MAX_GAP + 1) + 200) * CLK_NS;

  logic clk;
  logic arst_n;
  logic inst_valid;
  logic [INST_WIDTH-1:0] inst;
  logic [XLEN-1:0] pc;
  logic out_valid;
  logic wb_we;
  logic [REG_ADDR_WIDTH-1:0] wb_addr;
  logic [XLEN-1:0] wb_data;
  logic branch_taken;
  logic [XLEN-1:0] next_pc;
  logic lsu_req;
  logic lsu_store;
  logic [2:0] lsu_size;
  logic [XLEN-1:0] lsu_addr;
  logic [XLEN-1:0] lsu_wdata;

  logic [XLEN-1:0] model_regs [NUM_REGS];
  string test_name;
  logic [INST_WIDTH-1:0] stim_inst;
  logic [XLEN-1:0] stim_pc;
  logic exp_we;
  logic exp_taken;
  logic exp_req;
  logic exp_store;
  logic [REG_ADDR_WIDTH-1:0] exp_rd;
  logic [2:0] exp_size;
  logic [XLEN-1:0] exp_data;
  logic [XLEN-1:0] exp_next_pc;
  logic [XLEN-1:0] exp_addr;

  riscv_exec_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: instruction stream still running after %0d ns", TIMEOUT_NS);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check(input string name, input logic [XLEN-1:0] expected,
                       input logic [XLEN-1:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // RV32I integer result by funct3, alt selects sub / sra
  function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] x, input logic [XLEN-1:0] y);
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3: return (x < y) ? 32'd1 : 32'd0;
      3'd4: return x ^ y;
      3'd5: return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [XLEN-1:0] x,
                                      input logic [XLEN-1:0] y);
    case (f3)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return $signed(x) < $signed(y);
      3'd5: return $signed(x) >= $signed(y);
      3'd6: return x < y;
      default: return x >= y;
    endcase
  endfunction

  function automatic logic [REG_ADDR_WIDTH-1:0] pick_reg();
    if ($urandom_range(0, 3) != 0) return 5'($urandom_range(0, 5));  // hot set, reuse
    return 5'($urandom);
  endfunction

  // build one legal instruction of the given kind and its expected outputs
  task automatic gen_inst(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] off;
    logic [19:0] u20;
    logic [11:0] r12;
    logic [2:0] f3;
    logic alt;
    a = model_regs[rs1];
    b = model_regs[rs2];
    u20 = 20'($urandom);
    r12 = 12'($urandom);
    f3 = 3'($urandom_range(0, 7));
    alt = 1'($urandom_range(0, 1));
    imm = {{20{r12[11]}}, r12};
    stim_pc = $urandom & ~32'h3;
    exp_we = 1'b0;
    exp_taken = 1'b0;
    exp_req = 1'b0;
    exp_store = 1'b0;
    exp_rd = rd;
    exp_next_pc = stim_pc + 32'd4;
    case (kind)
      0: begin
        test_name = "op";
        alt = alt && (f3 == 3'd0 || f3 == 3'd5);
        stim_inst = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011};
        exp_we = 1'b1;
        exp_data = alu_ref(f3, alt, a, b);
      end
      1: begin
        test_name = "op_imm";
        alt = alt && f3 == 3'd5;
        if (f3 == 3'd1 || f3 == 3'd5) begin
          r12 = {alt ? 7'h20 : 7'h00, r12[4:0]};  // shamt
          imm = {20'b0, r12};
        end
        stim_inst = {r12, rs1, f3, rd, 7'b0010011};
        exp_we = 1'b1;
        exp_data = alu_ref(f3, alt, a, imm);
      end
      2, 3: begin
        test_name = (kind == 2) ? "lui" : "auipc";
        stim_inst = {u20, rd, (kind == 2) ? 7'b0110111 : 7'b0010111};
        exp_we = 1'b1;
        exp_data = (kind == 2) ? {u20, 12'b0} : stim_pc + {u20, 12'b0};
      end
      4: begin
        test_name = "branch";
        if (f3[2:1] == 2'b01) f3[1] = 1'b0;  // 010/011 are reserved
        off = {{19{r12[11]}}, r12, 1'b0};
        stim_inst = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
        exp_taken = branch_ref(f3, a, b);
        if (exp_taken) exp_next_pc = stim_pc + off;
      end
      5: begin
        test_name = "jal";
        off = {{11{u20[19]}}, u20, 1'b0};
        stim_inst = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
        exp_we = 1'b1;
        exp_data = stim_pc + 32'd4;
        exp_next_pc = stim_pc + off;
      end
      6: begin
        test_name = "jalr";
        stim_inst = {r12, rs1, 3'b000, rd, 7'b1100111};
        exp_we = 1'b1;
        exp_data = stim_pc + 32'd4;
        exp_next_pc = (a + imm) & ~32'h1;
      end
      7: begin
        test_name = "load";
        if (f3 == 3'd3 || f3[2:1] == 2'b11) f3 = 3'd2;
        stim_inst = {r12, rs1, f3, rd, 7'b0000011};
        exp_req = 1'b1;
        exp_addr = a + imm;
      end
      8: begin
        test_name = "store";
        f3 = 3'($urandom_range(0, 2));
        stim_inst = {r12[11:5], rs2, rs1, f3, r12[4:0], 7'b0100011};
        exp_req = 1'b1;
        exp_store = 1'b1;
        exp_addr = a + imm;
      end
      default: begin
        test_name = "fence/system";
        case ($urandom_range(0, 2))
          0: stim_inst = 32'h0ff0_000f;  // fence iorw, iorw
          1: stim_inst = 32'h0000_0073;  // ecall
          default: stim_inst = 32'h0010_0073;
        endcase
      end
    endcase
    exp_size = f3;
  endtask

  task automatic check_quiet(input string name);
    check({name, " out_valid"}, 32'd0, 32'(out_valid));
    check({name, " wb_we"}, 32'd0, 32'(wb_we));
    check({name, " branch_taken"}, 32'd0, 32'(branch_taken));
    check({name, " lsu_req"}, 32'd0, 32'(lsu_req));
  endtask

  // drive on the falling edge, compare one cycle later
  task automatic issue();
    inst_valid = 1'b1;
    inst = stim_inst;
    pc = stim_pc;
    @(negedge clk);
    inst_valid = 1'b0;
    check({test_name, " out_valid"}, 32'd1, 32'(out_valid));
    check({test_name, " wb_we"}, 32'(exp_we), 32'(wb_we));
    if (exp_we) begin
      check({test_name, " wb_addr"}, 32'(exp_rd), 32'(wb_addr));
      check({test_name, " wb_data"}, exp_data, wb_data);
    end
    check({test_name, " branch_taken"}, 32'(exp_taken), 32'(branch_taken));
    check({test_name, " next_pc"}, exp_next_pc, next_pc);
    check({test_name, " lsu_req"}, 32'(exp_req), 32'(lsu_req));
    if (exp_req) begin
      check({test_name, " lsu_store"}, 32'(exp_store), 32'(lsu_store));
      check({test_name, " lsu_size"}, 32'(exp_size), 32'(lsu_size));
      check({test_name, " lsu_addr"}, exp_addr, lsu_addr);
      if (exp_store) check({test_name, " lsu_wdata"}, model_regs[stim_inst[24:20]], lsu_wdata);
    end
    if (exp_we && exp_rd != '0) model_regs[exp_rd] = exp_data;
  endtask

  initial begin
    int gap;
    void'($urandom(72));
    for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
    arst_n = 1'b0;
    inst_valid = 1'b0;
    inst = '0;
    pc = '0;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_quiet("reset");
    end
    arst_n = 1'b1;
    @(negedge clk);
    check_quiet("after reset");
    gen_inst(8, 5'd3, 5'd1, 5'd2);  // reads before any write
    issue();
    gen_inst(2, 5'd0, 5'd3, 5'd2);  // write to x0
    issue();
    gen_inst(8, 5'd4, 5'd0, 5'd0);  // x0 on both read ports
    issue();
    for (int n = 0; n < NUM_INST; n++) begin
      gen_inst(int'($urandom_range(0, 9)), pick_reg(), pick_reg(), pick_reg());
      issue();
      gap = int'($urandom_range(0, MAX_GAP));
      repeat (gap) begin
        @(negedge clk);
        check_quiet("gap");
      end
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/riscv_exec_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_exec_chk import riscv_pkg::*; (
  input logic            clk,
  input logic            arst_n,
  input logic            inst_valid,
  input logic            out_valid,
  input logic            wb_we,
  input logic            branch_taken,
  input logic            lsu_req,
  input logic [XLEN-1:0] next_pc
);

  a_valid_follows: assert property (@(posedge clk) disable iff (!arst_n)
    inst_valid |=> out_valid) else $error("out_valid missing one cycle after inst_valid");

  a_valid_single: assert property (@(posedge clk) disable iff (!arst_n)
    !inst_valid |=> !out_valid) else $error("out_valid high without an instruction");

  a_strobes_valid: assert property (@(posedge clk) disable iff (!arst_n)
    (wb_we || lsu_req) |-> out_valid) else $error("wb_we or lsu_req without out_valid");

  a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> !next_pc[0]) else $error("next_pc has bit 0 set");

  a_reset_quiet: assert property (@(posedge clk)
    !arst_n |-> !(out_valid || wb_we || branch_taken || lsu_req))
    else $error("output strobe active during reset");

endmodule

bind riscv_exec_top riscv_exec_chk i_chk (
  .clk(clk), .arst_n(arst_n), .inst_valid(inst_valid), .out_valid(out_valid),
  .wb_we(wb_we), .branch_taken(branch_taken), .lsu_req(lsu_req), .next_pc(next_pc)
);

`default_nettype wire

/* rtl/riscv_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_exec_top import riscv_pkg::*; (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      inst_valid,
  input  logic [INST_WIDTH-1:0]     inst,
  input  logic [XLEN-1:0]           pc,
  output logic                      out_valid,
  output logic                      wb_we,
  output logic [REG_ADDR_WIDTH-1:0] wb_addr,
  output logic [XLEN-1:0]           wb_data,
  output logic                      branch_taken,
  output logic [XLEN-1:0]           next_pc,
  output logic                      lsu_req,
  output logic                      lsu_store,
  output logic [2:0]                lsu_size,
  output logic [XLEN-1:0]           lsu_addr,
  output logic [XLEN-1:0]           lsu_wdata
);

  logic [REG_ADDR_WIDTH-1:0] rs1_addr;
  logic [REG_ADDR_WIDTH-1:0] rs2_addr;
  logic [XLEN-1:0]           rs1_data;
  logic [XLEN-1:0]           rs2_data;
  logic [XLEN-1:0]           imm;

  riscv_ctrl_if ctrl_if ();

  assign rs1_addr = ctrl_if.rs1_zero ? '0 : inst[19:15];
  assign rs2_addr = inst[24:20];

  riscv_decode i_decode (.inst(inst), .ctrl(ctrl_if.ctrl));

  riscv_imm_gen i_imm_gen (.inst(inst), .ctrl(ctrl_if.dp), .imm(imm));

  riscv_regfile i_regfile (
    .clk(clk), .arst_n(arst_n),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .we(wb_we), .rd_addr(wb_addr), .rd_data(wb_data)  // registered writeback
  );

  riscv_execute i_execute (
    .clk(clk), .arst_n(arst_n), .inst_valid(inst_valid), .pc(pc),
    .rd_addr(inst[11:7]), .ctrl(ctrl_if.dp),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
    .out_valid(out_valid), .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data),
    .branch_taken(branch_taken), .next_pc(next_pc),
    .lsu_req(lsu_req), .lsu_store(lsu_store), .lsu_size(lsu_size),
    .lsu_addr(lsu_addr), .lsu_wdata(lsu_wdata)
  );

endmodule

`default_nettype wire

/* rtl/riscv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_execute import riscv_pkg::*; (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      inst_valid,
  input  logic [XLEN-1:0]           pc,
  input  logic [REG_ADDR_WIDTH-1:0] rd_addr,
  riscv_ctrl_if.dp                  ctrl,
  input  logic [XLEN-1:0]           rs1_data,
  input  logic [XLEN-1:0]           rs2_data,
  input  logic [XLEN-1:0]           imm,
  output logic                      out_valid,
  output logic                      wb_we,
  output logic [REG_ADDR_WIDTH-1:0] wb_addr,
  output logic [XLEN-1:0]           wb_data,
  output logic                      branch_taken,
  output logic [XLEN-1:0]           next_pc,
  output logic                      lsu_req,
  output logic                      lsu_store,
  output logic [2:0]                lsu_size,
  output logic [XLEN-1:0]           lsu_addr,
  output logic [XLEN-1:0]           lsu_wdata
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] jalr_sum;
  logic            br_cond;
  logic            taken;

  always_comb begin
    case (ctrl.src_sel)
      SRC_SEL_PC_IMM: begin op_a = pc;       op_b = imm;      end
      SRC_SEL_PC_4:   begin op_a = pc;       op_b = XLEN'(4); end
      SRC_SEL_RS1_2:  begin op_a = rs1_data; op_b = rs2_data; end
      default:        begin op_a = rs1_data; op_b = imm;      end
    endcase
  end

  always_comb begin
    case (ctrl.alu_op)
      ALU_SUB, ALU_SUBU: alu_res = op_a - op_b;
      ALU_SLL:  alu_res = op_a << op_b[4:0];
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = XLEN'($signed(op_a) >>> op_b[4:0]);
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      default:  alu_res = op_a + op_b;  // add, address, link
    endcase
  end

  always_comb begin
    case (ctrl.func_code)
      F3_BEQ:  br_cond = rs1_data == rs2_data;
      F3_BNE:  br_cond = rs1_data != rs2_data;
      F3_BLT:  br_cond = $signed(rs1_data) < $signed(rs2_data);
      F3_BGE:  br_cond = $signed(rs1_data) >= $signed(rs2_data);
      F3_BLTU: br_cond = rs1_data < rs2_data;
      F3_BGEU: br_cond = rs1_data >= rs2_data;
      default: br_cond = 1'b0;
    endcase
  end

  assign taken    = ctrl.is_branch && br_cond;
  assign jalr_sum = rs1_data + imm;

  always_comb begin
    if (taken || ctrl.is_jal) target = pc + imm;
    else if (ctrl.is_jalr) target = {jalr_sum[XLEN-1:1], 1'b0};
    else target = pc + XLEN'(4);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid    <= 1'b0;
      wb_we        <= 1'b0;
      branch_taken <= 1'b0;
      lsu_req      <= 1'b0;
    end else begin
      out_valid    <= inst_valid;
      wb_we        <= inst_valid && ctrl.rd_we;
      branch_taken <= inst_valid && taken;
      lsu_req      <= inst_valid && (ctrl.lsu_op != LSU_OPT_NONE);
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid) begin
      wb_addr   <= rd_addr;
      wb_data   <= alu_res;
      next_pc   <= target;
      lsu_store <= ctrl.lsu_op == LSU_OPT_STORE;
      lsu_size  <= ctrl.func_code;
      lsu_addr  <= alu_res;  // rs1 + imm
      lsu_wdata <= rs2_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/riscv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_regfile import riscv_pkg::*; (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic [REG_ADDR_WIDTH-1:0] rs1_addr,
  input  logic [REG_ADDR_WIDTH-1:0] rs2_addr,
  output logic [XLEN-1:0]           rs1_data,
  output logic [XLEN-1:0]           rs2_data,
  input  logic                      we,
  input  logic [REG_ADDR_WIDTH-1:0] rd_addr,
  input  logic [XLEN-1:0]           rd_data
);

  logic [XLEN-1:0] regs [1:NUM_REGS-1];

  // pending write is forwarded so the next instruction sees it
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_WIDTH-1:0] addr);
    if (addr == '0) return '0;
    if (we && addr == rd_addr) return rd_data;
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < NUM_REGS; i++) regs[i] <= '0;
    end else if (we && rd_addr != '0) begin  // x0 stays zero
      regs[rd_addr] <= rd_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/riscv_imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_imm_gen import riscv_pkg::*; (
  input  logic [INST_WIDTH-1:0] inst,
  riscv_ctrl_if.dp              ctrl,
  output logic [XLEN-1:0]       imm
);

  opcode_e         opcode;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign opcode = opcode_e'(inst[6:0]);

  assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    if (opcode == LUI || opcode == AUIPC) begin
      imm = imm_u;
    end else if (ctrl.is_jal) begin
      imm = imm_j;
    end else if (ctrl.is_branch) begin
      imm = imm_b;
    end else if (ctrl.lsu_op == LSU_OPT_STORE) begin
      imm = imm_s;
    end else begin
      imm = imm_i;  // op_imm, load, jalr
    end
  end

endmodule

`default_nettype wire

/* rtl/riscv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module riscv_decode import riscv_pkg::*; (
  input  logic [INST_WIDTH-1:0] inst,
  riscv_ctrl_if.ctrl            ctrl
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode         = opcode_e'(inst[6:0]);
  assign funct3         = inst[14:12];
  assign funct7         = inst[31:25];
  assign ctrl.func_code = funct3;

  always_comb begin
    ctrl.alu_op    = ALU_ADD;
    ctrl.src_sel   = SRC_SEL_RS1_IMM;
    ctrl.lsu_op    = LSU_OPT_NONE;
    ctrl.rd_we     = 1'b0;
    ctrl.is_branch = 1'b0;
    ctrl.is_jal    = 1'b0;
    ctrl.is_jalr   = 1'b0;
    ctrl.rs1_zero  = 1'b0;
    case (opcode)
      LUI: begin
        ctrl.rd_we    = 1'b1;
        ctrl.rs1_zero = 1'b1;  // x0 + imm
      end
      AUIPC: begin
        ctrl.src_sel = SRC_SEL_PC_IMM;
        ctrl.rd_we   = 1'b1;
      end
      JAL: begin
        ctrl.src_sel = SRC_SEL_PC_4;  // link value
        ctrl.rd_we   = 1'b1;
        ctrl.is_jal  = 1'b1;
      end
      JALR: begin
        ctrl.src_sel = SRC_SEL_PC_4;
        ctrl.rd_we   = 1'b1;
        ctrl.is_jalr = 1'b1;
      end
      BRANCH: begin
        ctrl.src_sel   = SRC_SEL_RS1_2;
        ctrl.is_branch = 1'b1;
        ctrl.alu_op    = (funct3[2:1] == 2'b11) ? ALU_SUBU : ALU_SUB;
      end
      LOAD:  ctrl.lsu_op = LSU_OPT_LOAD;
      STORE: ctrl.lsu_op = LSU_OPT_STORE;
      OP_IMM: begin
        ctrl.rd_we = 1'b1;
        case (funct3)
          3'b000: ctrl.alu_op = ALU_ADD;
          3'b010: ctrl.alu_op = ALU_SLT;
          3'b011: ctrl.alu_op = ALU_SLTU;
          3'b100: ctrl.alu_op = ALU_XOR;
          3'b110: ctrl.alu_op = ALU_OR;
          3'b111: ctrl.alu_op = ALU_AND;
          3'b001: begin
            if (funct7 == F7_BASE) ctrl.alu_op = ALU_SLL;
            else ctrl.rd_we = 1'b0;
          end
          default: begin  // 101, srli / srai
            if (funct7 == F7_BASE) ctrl.alu_op = ALU_SRL;
            else if (funct7 == F7_ALT) ctrl.alu_op = ALU_SRA;
            else ctrl.rd_we = 1'b0;
          end
        endcase
      end
      OP: begin
        ctrl.src_sel = SRC_SEL_RS1_2;
        ctrl.rd_we   = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, 3'b000}: ctrl.alu_op = ALU_ADD;
          {F7_ALT,  3'b000}: ctrl.alu_op = ALU_SUB;
          {F7_BASE, 3'b001}: ctrl.alu_op = ALU_SLL;
          {F7_BASE, 3'b010}: ctrl.alu_op = ALU_SLT;
          {F7_BASE, 3'b011}: ctrl.alu_op = ALU_SLTU;
          {F7_BASE, 3'b100}: ctrl.alu_op = ALU_XOR;
          {F7_BASE, 3'b101}: ctrl.alu_op = ALU_SRL;
          {F7_ALT,  3'b101}: ctrl.alu_op = ALU_SRA;
          {F7_BASE, 3'b110}: ctrl.alu_op = ALU_OR;
          {F7_BASE, 3'b111}: ctrl.alu_op = ALU_AND;
          default:           ctrl.rd_we  = 1'b0;  // bad funct7
        endcase
      end
      FENCE, SYS: ctrl.alu_op = ALU_AND;  // no-op here
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/riscv_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface riscv_ctrl_if import riscv_pkg::*; ();

  alu_op_e    alu_op;
  src_sel_e   src_sel;
  lsu_op_e    lsu_op;
  logic [2:0] func_code;
  logic       rd_we;
  logic       is_branch;
  logic       is_jal;
  logic       is_jalr;
  logic       rs1_zero;   // lui reads x0 as operand a

  modport ctrl (
    output alu_op, src_sel, lsu_op, func_code, rd_we,
    output is_branch, is_jal, is_jalr, rs1_zero
  );

  modport dp (
    input alu_op, src_sel, lsu_op, func_code, rd_we,
    input is_branch, is_jal, is_jalr, rs1_zero
  );

endinterface

`default_nettype wire

/* rtl/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

  localparam int XLEN           = 32;
  localparam int INST_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int NUM_REGS       = 2 ** REG_ADDR_WIDTH;

  // funct7 patterns for OP and the OP_IMM shifts
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;

  // branch conditions in funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    LUI    = 7'b011_0111,
    AUIPC  = 7'b001_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    BRANCH = 7'b110_0011,
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011,
    OP_IMM = 7'b001_0011,
    OP     = 7'b011_0011,
    FENCE  = 7'b000_1111,
    SYS    = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SUBU = 4'd2,
    ALU_SLL  = 4'd3,
    ALU_SLT  = 4'd4,
    ALU_SLTU = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_SRL  = 4'd7,
    ALU_SRA  = 4'd8,
    ALU_OR   = 4'd9,
    ALU_AND  = 4'd10
  } alu_op_e;

  // operand a / operand b
  typedef enum logic [1:0] {
    SRC_SEL_RS1_IMM = 2'd0,  // rs1 / imm
    SRC_SEL_PC_IMM  = 2'd1,  // pc / imm
    SRC_SEL_PC_4    = 2'd2,  // pc / 4
    SRC_SEL_RS1_2   = 2'd3   // rs1 / rs2
  } src_sel_e;

  typedef enum logic [1:0] {
    LSU_OPT_NONE  = 2'd0,
    LSU_OPT_LOAD  = 2'd1,
    LSU_OPT_STORE = 2'd2
  } lsu_op_e;

endpackage

`default_nettype wire
